// File: src/idct_pkg.sv
`default_nettype none

package idct_pkg;

	// picture geometry, in 8x8 blocks
	localparam int BLOCK_DIM = 8;
	localparam int BLOCKS_X = 4;
	localparam int BLOCKS_Y = 2;
	localparam int IMAGE_WIDTH = BLOCKS_X * BLOCK_DIM;

	// sram regions
	localparam logic [17:0] PRE_IDCT_BASE = 18'd76800;
	localparam logic [17:0] PIXEL_BASE = 18'd0;
	localparam int PIXEL_STRIDE = IMAGE_WIDTH / 2;
	localparam int PIXEL_WORDS = BLOCKS_Y * BLOCK_DIM * PIXEL_STRIDE;

	// fixed point
	localparam int COEF_W = 16;
	localparam int T_W = 16;
	localparam int PIXEL_W = 8;
	localparam int T_SHIFT = 8;
	localparam int S_SHIFT = 16;
	localparam int RAM_AW = 5;

	// [j][k] = 4096 * c(k) * cos((2j+1)k*pi/16)
	localparam logic signed [15:0] COS_TABLE [8][8] = '{
		'{16'sd1448,  16'sd2009,  16'sd1892,  16'sd1703,
		  16'sd1448,  16'sd1138,  16'sd784,   16'sd400},
		'{16'sd1448,  16'sd1703,  16'sd784,  -16'sd400,
		 -16'sd1448, -16'sd2009, -16'sd1892, -16'sd1138},
		'{16'sd1448,  16'sd1138, -16'sd784,  -16'sd2009,
		 -16'sd1448,  16'sd400,   16'sd1892,  16'sd1703},
		'{16'sd1448,  16'sd400,  -16'sd1892, -16'sd1138,
		  16'sd1448,  16'sd1703, -16'sd784,  -16'sd2009},
		'{16'sd1448, -16'sd400,  -16'sd1892,  16'sd1138,
		  16'sd1448, -16'sd1703, -16'sd784,   16'sd2009},
		'{16'sd1448, -16'sd1138, -16'sd784,   16'sd2009,
		 -16'sd1448, -16'sd400,   16'sd1892, -16'sd1703},
		'{16'sd1448, -16'sd1703,  16'sd784,   16'sd400,
		 -16'sd1448,  16'sd2009, -16'sd1892,  16'sd1138},
		'{16'sd1448, -16'sd2009,  16'sd1892, -16'sd1703,
		  16'sd1448, -16'sd1138,  16'sd784,  -16'sd400}
	};

	typedef struct packed {
		logic [17:0] address;
		logic [15:0] write_data;
		logic write_en_n;
	} sram_req_t;

	typedef struct packed {
		logic signed [COEF_W-1:0] even;
		logic signed [COEF_W-1:0] odd;
	} coef_pair_t;

	typedef struct packed {
		logic signed [T_W-1:0] even;
		logic signed [T_W-1:0] odd;
	} t_pair_t;

	typedef enum logic [4:0] {
		PH_IDLE  = 5'b00001,
		PH_FETCH = 5'b00010,
		PH_COL   = 5'b00100,
		PH_ROW   = 5'b01000,
		PH_WRITE = 5'b10000
	} phase_t;

	// write side of the coefficient buffer
	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		logic write_en;
		coef_pair_t write_data;
	} coef_port_t;

endpackage

`default_nettype wire

// File: src/pair_ram.sv
`timescale 1ns/100ps
`default_nettype none

module pair_ram #(
	parameter type payload_t = logic [31:0]
) (
	input logic CLOCK_50_I,
	input logic [idct_pkg::RAM_AW-1:0] addr_a,
	input logic [idct_pkg::RAM_AW-1:0] addr_b,
	input logic we_a,
	input logic we_b,
	input payload_t wdata_a,
	input payload_t wdata_b,
	output payload_t rdata_a,
	output payload_t rdata_b
);
	import idct_pkg::*;

	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		logic write_en;
		payload_t write_data;
	} ram_port_t;

	payload_t mem [2**RAM_AW];
	ram_port_t port_a, port_b;

	assign port_a = '{addr: addr_a, write_en: we_a, write_data: wdata_a};
	assign port_b = '{addr: addr_b, write_en: we_b, write_data: wdata_b};

	// read returns the old word on a same-port write
	always_ff @(posedge CLOCK_50_I) begin
		if (port_a.write_en)
			mem[port_a.addr] <= port_a.write_data;
		if (port_b.write_en)
			mem[port_b.addr] <= port_b.write_data;
		rdata_a <= mem[port_a.addr];
		rdata_b <= mem[port_b.addr];
	end

	no_write_clash: assert property (@(posedge CLOCK_50_I)
		!(port_a.write_en && port_b.write_en && port_a.addr == port_b.addr));

endmodule

`default_nettype wire

// File: src/frame_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module frame_sequencer (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic fetch_done,
	input logic col_done,
	input logic row_done,
	input logic write_done,
	output logic fetch_go,
	output logic col_go,
	output logic row_go,
	output logic write_go,
	output logic [$clog2(idct_pkg::BLOCKS_X)-1:0] block_col,
	output logic [$clog2(idct_pkg::BLOCKS_Y)-1:0] block_row,
	output logic finish
);
	import idct_pkg::*;

	phase_t phase;
	logic last_block;

	assign last_block = (block_col == BLOCKS_X - 1) && (block_row == BLOCKS_Y - 1);

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			phase <= PH_IDLE;
			block_col <= '0;
			block_row <= '0;
			fetch_go <= 1'b0;
			col_go <= 1'b0;
			row_go <= 1'b0;
			write_go <= 1'b0;
		end else begin
			fetch_go <= 1'b0;
			col_go <= 1'b0;
			row_go <= 1'b0;
			write_go <= 1'b0;
			case (phase)
				PH_IDLE: if (start) begin
					block_col <= '0;
					block_row <= '0;
					fetch_go <= 1'b1;
					phase <= PH_FETCH;
				end
				PH_FETCH: if (fetch_done) begin
					col_go <= 1'b1;
					phase <= PH_COL;
				end
				PH_COL: if (col_done) begin
					row_go <= 1'b1;
					phase <= PH_ROW;
				end
				PH_ROW: if (row_done) begin
					write_go <= 1'b1;
					phase <= PH_WRITE;
				end
				PH_WRITE: if (write_done) begin
					if (last_block) begin
						phase <= PH_IDLE;
					end else begin
						// column first, then next block row
						block_col <= block_col + 1'b1;
						if (block_col == BLOCKS_X - 1)
							block_row <= block_row + 1'b1;
						fetch_go <= 1'b1;
						phase <= PH_FETCH;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// the cycle after the final sram write
	assign finish = (phase == PH_WRITE) && write_done && last_block;

	phase_onehot: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		$onehot(phase));

endmodule

`default_nettype wire

// File: src/block_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module block_fetch (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic go,
	input logic [$clog2(idct_pkg::BLOCKS_X)-1:0] block_col,
	input logic [$clog2(idct_pkg::BLOCKS_Y)-1:0] block_row,
	output idct_pkg::sram_req_t sram_req,
	input logic [15:0] sram_read_data,
	output idct_pkg::coef_port_t coef_port,
	output logic done
);
	import idct_pkg::*;

	logic [17:0] base_addr;
	logic [17:0] rd_addr;
	logic [5:0] rd_cnt;
	logic busy;
	logic valid_d1, valid_d2;
	logic [5:0] idx_d1, idx_d2;
	logic [COEF_W-1:0] even_q;

	assign base_addr = PRE_IDCT_BASE
		+ 18'(block_row) * 18'(BLOCK_DIM * IMAGE_WIDTH)
		+ 18'(block_col) * 18'(BLOCK_DIM);

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			busy <= 1'b0;
			rd_cnt <= '0;
			rd_addr <= '0;
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
		end else begin
			valid_d1 <= busy;
			valid_d2 <= valid_d1;
			if (go) begin
				busy <= 1'b1;
				rd_cnt <= '0;
				rd_addr <= base_addr;
			end else if (busy) begin
				rd_cnt <= rd_cnt + 6'd1;
				// end of a block row jumps to the next picture row
				if (rd_cnt[2:0] == 3'd7)
					rd_addr <= rd_addr + 18'(IMAGE_WIDTH - BLOCK_DIM + 1);
				else
					rd_addr <= rd_addr + 18'd1;
				if (rd_cnt == 6'd63)
					busy <= 1'b0;
			end
		end
	end

	// index of the word that arrives two cycles after its address
	always_ff @(posedge CLOCK_50_I) begin
		idx_d1 <= rd_cnt;
		idx_d2 <= idx_d1;
		if (valid_d2 && !idx_d2[0])
			even_q <= sram_read_data;
	end

	assign sram_req.address = rd_addr;
	assign sram_req.write_data = '0;
	assign sram_req.write_en_n = 1'b1;

	assign coef_port.addr = idx_d2[5:1];
	assign coef_port.write_en = valid_d2 && idx_d2[0];
	assign coef_port.write_data.even = even_q;
	assign coef_port.write_data.odd = sram_read_data;

	assign done = valid_d2 && (idx_d2 == 6'd63);

endmodule

`default_nettype wire

// File: src/idct_pass.sv
`timescale 1ns/100ps
`default_nettype none

module idct_pass #(
	parameter type in_pair_t = idct_pkg::coef_pair_t,
	parameter type out_pair_t = idct_pkg::t_pair_t,
	parameter int SHIFT = 8,
	parameter bit TRANSPOSE = 1'b0,
	parameter bit CLIP = 1'b0
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic go,
	output logic [idct_pkg::RAM_AW-1:0] rd_addr_a,
	output logic [idct_pkg::RAM_AW-1:0] rd_addr_b,
	input in_pair_t rd_data_a,
	input in_pair_t rd_data_b,
	output logic wr_en,
	output logic [idct_pkg::RAM_AW-1:0] wr_addr,
	output out_pair_t wr_data,
	output logic done
);
	import idct_pkg::*;

	localparam int IW = $bits(in_pair_t) / 2;
	localparam int OW = $bits(out_pair_t) / 2;

	// cnt = {row r, column pair, half, step m}
	logic [7:0] cnt, ctl_d1, ctl_d2;
	logic run, valid_d1, valid_d2;
	logic [IW*2-1:0] raw_a, raw_b;
	logic signed [IW-1:0] a_val, b_val;
	logic signed [15:0] coef0, coef1;
	logic signed [31:0] prod0, prod1, term_sum;
	logic signed [31:0] acc_even, acc_odd;
	logic [2:0] r1, c1, k0, k1;

	function automatic logic [OW-1:0] scale(input logic signed [31:0] s);
		logic signed [31:0] v;
		v = s >>> SHIFT;
		if (CLIP) begin
			if (v < 0)
				v = 0;
			else if (v > 255)
				v = 255;
		end
		return v[OW-1:0];
	endfunction

	// column pass walks a row of S', row pass walks a column of T
	assign rd_addr_a = TRANSPOSE ? {cnt[1:0], 1'b0, cnt[4:3]} : {cnt[7:5], cnt[1:0]};
	assign rd_addr_b = TRANSPOSE ? {cnt[1:0], 1'b1, cnt[4:3]} : {cnt[7:5], cnt[1:0]};

	assign r1 = ctl_d1[7:5];
	assign c1 = ctl_d1[4:2];
	assign k0 = {ctl_d1[1:0], 1'b0};
	assign k1 = {ctl_d1[1:0], 1'b1};
	assign raw_a = rd_data_a;
	assign raw_b = rd_data_b;

	always_comb begin
		if (TRANSPOSE) begin
			a_val = c1[0] ? raw_a[IW-1:0] : raw_a[2*IW-1:IW];
			b_val = c1[0] ? raw_b[IW-1:0] : raw_b[2*IW-1:IW];
			coef0 = COS_TABLE[r1][k0];
			coef1 = COS_TABLE[r1][k1];
		end else begin
			a_val = raw_a[2*IW-1:IW];
			b_val = raw_b[IW-1:0];
			coef0 = COS_TABLE[c1][k0];
			coef1 = COS_TABLE[c1][k1];
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			run <= 1'b0;
			cnt <= '0;
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
		end else begin
			valid_d1 <= run;
			valid_d2 <= valid_d1;
			if (go) begin
				run <= 1'b1;
				cnt <= '0;
			end else if (run) begin
				cnt <= cnt + 8'd1;
				if (cnt == 8'hff)
					run <= 1'b0;
			end
		end
	end

	// registered multipliers, one term each per cycle
	always_ff @(posedge CLOCK_50_I) begin
		ctl_d1 <= cnt;
		ctl_d2 <= ctl_d1;
		prod0 <= a_val * coef0;
		prod1 <= b_val * coef1;
	end

	assign term_sum = prod0 + prod1;

	// accumulate two cycles behind the reads
	always_ff @(posedge CLOCK_50_I) begin
		if (valid_d2 && !ctl_d2[2])
			acc_even <= (ctl_d2[1:0] == 2'd0 ? 32'sd0 : acc_even) + term_sum;
		if (valid_d2 && ctl_d2[2] && ctl_d2[1:0] != 2'd3)
			acc_odd <= (ctl_d2[1:0] == 2'd0 ? 32'sd0 : acc_odd) + term_sum;
		wr_addr <= ctl_d2[7:3];
		wr_data <= out_pair_t'({scale(acc_even), scale(acc_odd + term_sum)});
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			wr_en <= 1'b0;
			done <= 1'b0;
		end else begin
			wr_en <= valid_d2 && ctl_d2[2] && (ctl_d2[1:0] == 2'd3);
			done <= valid_d2 && (ctl_d2 == 8'hff);
		end
	end

endmodule

`default_nettype wire

// File: src/pixel_writer.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_writer (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic go,
	input logic [$clog2(idct_pkg::BLOCKS_X)-1:0] block_col,
	input logic [$clog2(idct_pkg::BLOCKS_Y)-1:0] block_row,
	input logic pix_valid,
	input logic [2*idct_pkg::PIXEL_W-1:0] pix_pair,
	output idct_pkg::sram_req_t sram_req,
	output logic done
);
	import idct_pkg::*;

	logic [2*PIXEL_W-1:0] pix_buf [32];
	logic [4:0] fill_cnt, wr_cnt;
	logic busy, last_wr;
	logic [17:0] base_addr, wr_addr;

	assign base_addr = PIXEL_BASE
		+ 18'(block_row) * 18'(BLOCK_DIM * PIXEL_STRIDE)
		+ 18'(block_col) * 18'(BLOCK_DIM / 2);
	// four words per pixel row, then the output stride
	assign wr_addr = base_addr + 18'(wr_cnt[4:2]) * 18'(PIXEL_STRIDE) + 18'(wr_cnt[1:0]);

	// pairs arrive during the row pass, in raster order
	always_ff @(posedge CLOCK_50_I) begin
		if (pix_valid)
			pix_buf[fill_cnt] <= pix_pair;
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			fill_cnt <= '0;
			wr_cnt <= '0;
			busy <= 1'b0;
			last_wr <= 1'b0;
			done <= 1'b0;
			sram_req.address <= '0;
			sram_req.write_data <= '0;
			sram_req.write_en_n <= 1'b1;
		end else begin
			if (pix_valid)
				fill_cnt <= fill_cnt + 5'd1;
			last_wr <= busy && (wr_cnt == 5'd31);
			done <= last_wr;
			sram_req.write_en_n <= !busy;
			if (busy) begin
				sram_req.address <= wr_addr;
				sram_req.write_data <= pix_buf[wr_cnt];
			end
			if (go) begin
				busy <= 1'b1;
				wr_cnt <= '0;
			end else if (busy) begin
				wr_cnt <= wr_cnt + 5'd1;
				if (wr_cnt == 5'd31)
					busy <= 1'b0;
			end
		end
	end

	in_pixel_region: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!sram_req.write_en_n |-> sram_req.address < PIXEL_BASE + 18'(PIXEL_WORDS));

endmodule

`default_nettype wire

// File: src/idct_top.sv
`timescale 1ns/100ps
`default_nettype none

module idct_top (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic [15:0] sram_read_data,
	output idct_pkg::sram_req_t sram_req,
	output logic finish
);
	import idct_pkg::*;

	logic fetch_go, col_go, row_go, write_go;
	logic fetch_done, col_done, row_done, write_done;
	logic [$clog2(BLOCKS_X)-1:0] block_col;
	logic [$clog2(BLOCKS_Y)-1:0] block_row;

	sram_req_t fetch_req, writer_req;
	coef_port_t coef_port;

	logic [RAM_AW-1:0] col_rd_a, col_rd_b, col_wr_addr, coef_addr_a;
	logic [RAM_AW-1:0] row_rd_a, row_rd_b, t_addr_a;
	coef_pair_t coef_rdata_a, coef_rdata_b;
	t_pair_t col_wr_data, t_rdata_a, t_rdata_b;
	logic col_wr_en;
	logic pix_valid;
	logic [2*PIXEL_W-1:0] pix_pair;

	frame_sequencer i_seq (
		.CLOCK_50_I(CLOCK_50_I), .Resetn(Resetn), .start(start),
		.fetch_done(fetch_done), .col_done(col_done),
		.row_done(row_done), .write_done(write_done),
		.fetch_go(fetch_go), .col_go(col_go), .row_go(row_go), .write_go(write_go),
		.block_col(block_col), .block_row(block_row), .finish(finish)
	);

	block_fetch i_fetch (
		.CLOCK_50_I(CLOCK_50_I), .Resetn(Resetn), .go(fetch_go),
		.block_col(block_col), .block_row(block_row),
		.sram_req(fetch_req), .sram_read_data(sram_read_data),
		.coef_port(coef_port), .done(fetch_done)
	);

	// fetch owns port A only while it is writing
	assign coef_addr_a = coef_port.write_en ? coef_port.addr : col_rd_a;

	pair_ram #(.payload_t(coef_pair_t)) i_coef_ram (
		.CLOCK_50_I(CLOCK_50_I),
		.addr_a(coef_addr_a), .addr_b(col_rd_b),
		.we_a(coef_port.write_en), .we_b(1'b0),
		.wdata_a(coef_port.write_data), .wdata_b('0),
		.rdata_a(coef_rdata_a), .rdata_b(coef_rdata_b)
	);

	idct_pass #(
		.in_pair_t(coef_pair_t), .out_pair_t(t_pair_t),
		.SHIFT(T_SHIFT), .TRANSPOSE(1'b0), .CLIP(1'b0)
	) i_col_pass (
		.CLOCK_50_I(CLOCK_50_I), .Resetn(Resetn), .go(col_go),
		.rd_addr_a(col_rd_a), .rd_addr_b(col_rd_b),
		.rd_data_a(coef_rdata_a), .rd_data_b(coef_rdata_b),
		.wr_en(col_wr_en), .wr_addr(col_wr_addr), .wr_data(col_wr_data),
		.done(col_done)
	);

	assign t_addr_a = col_wr_en ? col_wr_addr : row_rd_a;

	pair_ram #(.payload_t(t_pair_t)) i_t_ram (
		.CLOCK_50_I(CLOCK_50_I),
		.addr_a(t_addr_a), .addr_b(row_rd_b),
		.we_a(col_wr_en), .we_b(1'b0),
		.wdata_a(col_wr_data), .wdata_b('0),
		.rdata_a(t_rdata_a), .rdata_b(t_rdata_b)
	);

	idct_pass #(
		.in_pair_t(t_pair_t), .out_pair_t(logic [2*PIXEL_W-1:0]),
		.SHIFT(S_SHIFT), .TRANSPOSE(1'b1), .CLIP(1'b1)
	) i_row_pass (
		.CLOCK_50_I(CLOCK_50_I), .Resetn(Resetn), .go(row_go),
		.rd_addr_a(row_rd_a), .rd_addr_b(row_rd_b),
		.rd_data_a(t_rdata_a), .rd_data_b(t_rdata_b),
		.wr_en(pix_valid), .wr_addr(), .wr_data(pix_pair),
		.done(row_done)
	);

	pixel_writer i_writer (
		.CLOCK_50_I(CLOCK_50_I), .Resetn(Resetn), .go(write_go),
		.block_col(block_col), .block_row(block_row),
		.pix_valid(pix_valid), .pix_pair(pix_pair),
		.sram_req(writer_req), .done(write_done)
	);

	// writer holds the bus during the write phase, fetch otherwise
	assign sram_req = writer_req.write_en_n ? fetch_req : writer_req;

endmodule

`default_nettype wire

// File: include/idct_tb_model.svh
`ifndef IDCT_TB_MODEL_SVH
`define IDCT_TB_MODEL_SVH

typedef logic [15:0] sram_mem_t [2**18];
typedef logic signed [15:0] coef_blk_t [8][8];
typedef logic [7:0] pix_blk_t [8][8];

// galois lfsr, one step per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [15:0] lfsr_bits(ref logic [31:0] s, input int n);
	logic [15:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		s = lfsr_next(s);
		v = {v[14:0], s[0]};
	end
	return v;
endfunction

// T = (S' x C) >>> 8 kept to 16 bits, then S = (C^T x T) >>> 16 and clip
function automatic pix_blk_t model_idct(input coef_blk_t sp);
	logic signed [15:0] t [8][8];
	pix_blk_t p;
	int acc;
	for (int r = 0; r < 8; r++)
		for (int c = 0; c < 8; c++) begin
			acc = 0;
			for (int k = 0; k < 8; k++)
				acc += int'(sp[r][k]) * int'(COS_TABLE[c][k]);
			t[r][c] = 16'(acc >>> T_SHIFT);
		end
	for (int r = 0; r < 8; r++)
		for (int c = 0; c < 8; c++) begin
			acc = 0;
			for (int k = 0; k < 8; k++)
				acc += int'(COS_TABLE[r][k]) * int'(t[k][c]);
			acc = acc >>> S_SHIFT;
			p[r][c] = (acc < 0) ? 8'd0 : (acc > 255) ? 8'd255 : 8'(acc);
		end
	return p;
endfunction

task automatic load_coef_block(ref sram_mem_t mem, input int bc, input int br,
	input coef_blk_t sp);
	int base;
	base = PRE_IDCT_BASE + br * BLOCK_DIM * IMAGE_WIDTH + bc * BLOCK_DIM;
	for (int r = 0; r < 8; r++)
		for (int c = 0; c < 8; c++)
			mem[base + r * IMAGE_WIDTH + c] = sp[r][c];
endtask

function automatic int pixel_word_addr(input int bc, input int br, input int r, input int w);
	return PIXEL_BASE + (br * BLOCK_DIM + r) * PIXEL_STRIDE + bc * (BLOCK_DIM / 2) + w;
endfunction

function automatic logic [15:0] expected_word(input pix_blk_t p, input int r, input int w);
	return {p[r][2*w], p[r][2*w+1]};
endfunction

`endif

// File: verification/tb_idct.sv
`timescale 1ns/100ps
`default_nettype none

module tb_idct;
	import idct_pkg::*;
	`include "idct_tb_model.svh"

	logic CLOCK_50_I;
	logic Resetn;
	logic start;
	logic [15:0] sram_read_data;
	sram_req_t sram_req;
	logic finish;

	// behavioural sram with a two-stage read pipe
	sram_mem_t sram;
	logic [15:0] rd_stage;

	logic [31:0] seed;
	coef_blk_t frame_coef [BLOCKS_X][BLOCKS_Y];
	logic [15:0] coef_copy [BLOCKS_Y * BLOCK_DIM * IMAGE_WIDTH];
	int errors;
	int checks;
	int cycles;
	int finish_cnt;
	int write_cnt;
	int clip_lo;
	int clip_hi;

	idct_top i_dut (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.sram_read_data(sram_read_data),
		.sram_req(sram_req),
		.finish(finish)
	);

	initial begin
		CLOCK_50_I = 1'b0;
		forever #20 CLOCK_50_I = ~CLOCK_50_I;
	end

	always @(posedge CLOCK_50_I) begin
		rd_stage <= sram[sram_req.address];
		sram_read_data <= rd_stage;
		if (sram_req.write_en_n === 1'b0) begin
			write_cnt++;
			assert (sram_req.address < PIXEL_BASE + 18'(PIXEL_WORDS)) else begin
				errors++;
				$display("sram write to address %0d lies outside the output region",
					sram_req.address);
			end
			sram[sram_req.address] <= sram_req.write_data;
		end
	end

	always @(negedge CLOCK_50_I) begin
		if (finish === 1'b1)
			finish_cnt++;
	end

	// 8 frames of 8 blocks at about 600 cycles each
	always @(posedge CLOCK_50_I) begin
		cycles++;
		if (cycles >= 8 * BLOCKS_X * BLOCKS_Y * 600) begin
			$display("run stopped after %0d cycles, the DUT never finished", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// never zero inside the output region
	function automatic logic [15:0] fill_word(input int a);
		return 16'((a + 1) * 40503) ^ 16'(a >> 7);
	endfunction

	function automatic logic signed [15:0] rand_val(input int bits, input bit sgn);
		logic [15:0] v;
		if (bits == 0)
			return '0;
		v = lfsr_bits(seed, bits);
		if (sgn && v[bits-1])
			v = v | (16'hffff << bits);
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic pulse_start();
		@(posedge CLOCK_50_I);
		start <= 1'b1;
		@(posedge CLOCK_50_I);
		start <= 1'b0;
	endtask

	// dc term and ac terms drawn with their own widths
	task automatic gen_frame(input int dc_bits, input bit dc_signed, input int ac_bits);
		for (int bc = 0; bc < BLOCKS_X; bc++) begin
			for (int br = 0; br < BLOCKS_Y; br++) begin
				for (int r = 0; r < 8; r++) begin
					for (int c = 0; c < 8; c++) begin
						if (r == 0 && c == 0)
							frame_coef[bc][br][r][c] = rand_val(dc_bits, dc_signed);
						else
							frame_coef[bc][br][r][c] = rand_val(ac_bits, 1'b1);
					end
				end
				load_coef_block(sram, bc, br, frame_coef[bc][br]);
			end
		end
	endtask

	task automatic run_frame(input string name, input bit mid_start);
		int base_finish;
		int base_writes;
		for (int i = 0; i < BLOCKS_Y * BLOCK_DIM * IMAGE_WIDTH; i++)
			coef_copy[i] = sram[PRE_IDCT_BASE + i];
		// stale pixels from the last frame must not pass as results
		for (int a = 0; a < PIXEL_WORDS; a++)
			sram[PIXEL_BASE + a] = fill_word(PIXEL_BASE + a);
		base_finish = finish_cnt;
		base_writes = write_cnt;
		pulse_start();
		if (mid_start) begin
			repeat (1500) @(posedge CLOCK_50_I);
			pulse_start();
		end
		do
			@(negedge CLOCK_50_I);
		while (finish !== 1'b1);
		// room for a stray second finish or extra writes
		repeat (20) @(negedge CLOCK_50_I);
		check_value({name, " finish pulses"}, 1, finish_cnt - base_finish);
		check_value({name, " output writes"}, BLOCKS_X * BLOCKS_Y * 32,
			write_cnt - base_writes);
	endtask

	task automatic check_frame(input string name, input bit flat);
		pix_blk_t p;
		logic [15:0] exp;
		for (int bc = 0; bc < BLOCKS_X; bc++) begin
			for (int br = 0; br < BLOCKS_Y; br++) begin
				p = model_idct(frame_coef[bc][br]);
				for (int r = 0; r < 8; r++) begin
					for (int w = 0; w < 4; w++) begin
						exp = flat ? {p[0][0], p[0][0]} : expected_word(p, r, w);
						for (int h = 0; h < 2; h++) begin
							if (p[r][2*w+h] == 8'd0)
								clip_lo++;
							if (p[r][2*w+h] == 8'd255)
								clip_hi++;
						end
						check_value($sformatf("%s block (%0d,%0d) row %0d word %0d",
							name, bc, br, r, w), exp, sram[pixel_word_addr(bc, br, r, w)]);
					end
				end
			end
		end
		for (int i = 0; i < BLOCKS_Y * BLOCK_DIM * IMAGE_WIDTH; i++)
			check_value($sformatf("%s coefficient word %0d", name, i), coef_copy[i],
				sram[PRE_IDCT_BASE + i]);
	endtask

	initial begin
		seed = 32'hf4d8;
		errors = 0;
		checks = 0;
		cycles = 0;
		finish_cnt = 0;
		write_cnt = 0;
		clip_lo = 0;
		clip_hi = 0;
		Resetn = 1'b0;
		start = 1'b0;
		sram_read_data = '0;
		rd_stage = '0;
		for (int a = 0; a < 2**18; a++)
			sram[a] = fill_word(a);
		repeat (5) @(posedge CLOCK_50_I);
		Resetn <= 1'b1;
		repeat (10) @(negedge CLOCK_50_I);
		check_value("finish after reset", 0, finish_cnt);
		check_value("write enable after reset", 1, sram_req.write_en_n);

		gen_frame(0, 1'b0, 0);
		run_frame("zero", 1'b0);
		check_frame("zero", 1'b1);

		// one flat value per block
		gen_frame(11, 1'b0, 0);
		run_frame("dc only", 1'b0);
		check_frame("dc only", 1'b1);

		// frame 1 also sees a start while busy
		for (int f = 0; f < 3; f++) begin
			gen_frame(11, 1'b0, 8);
			run_frame($sformatf("random %0d", f), f == 1);
			check_frame($sformatf("random %0d", f), 1'b0);
		end

		clip_lo = 0;
		clip_hi = 0;
		gen_frame(12, 1'b1, 12);
		run_frame("large", 1'b0);
		check_frame("large", 1'b0);
		checks++;
		assert (clip_lo > 0 && clip_hi > 0) else begin
			errors++;
			$display("large frame did not drive pixels to both 0 and 255");
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
src/idct_pkg.sv
src/pair_ram.sv
src/frame_sequencer.sv
src/block_fetch.sv
src/idct_pass.sv
src/pixel_writer.sv
src/idct_top.sv
verification/tb_idct.sv

// File: Bender.yml
package:
  name: idct

sources:
  - target: rtl
    files:
      - src/idct_pkg.sv
      - src/pair_ram.sv
      - src/frame_sequencer.sv
      - src/block_fetch.sv
      - src/idct_pass.sv
      - src/pixel_writer.sv
      - src/idct_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_idct.sv
